/* vlog.f */
+incdir+testbench
common/core_pkg.sv
execute/alu.sv
execute/execute_stage.sv
hdl/decode_stage.sv
hdl/reg_file.sv
hdl/core_top.sv
testbench/tb_core.sv

/* run.sh */
#!/bin/sh
# build and run tb_core with Verilator, the log decides the verdict
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f vlog.f --top-module tb_core -Mdir obj_dir -o tb_core
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_core > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "SIMULATION FAILED" "$LOG"; then
    exit 1
fi
exit 0

/* testbench/tb_vectors.svh */
task automatic load_vectors();
    begin
        // each row gives pc, instruction word and the expected trace we, rd and data
        // data is only compared when we is expected high
        // base values r1 = 5, r2 = -3, r3 = 0x7ff
        add_row(32'h1c000000, i12(core_pkg::OP_ADDI_W, 1, 0, 12'h005), 1, 1, 32'h5);
        add_row(32'h1c000004, i12(core_pkg::OP_ADDI_W, 2, 0, 12'hffd), 1, 2, 32'hfffffffd);
        add_row(32'h1c000008, i12(core_pkg::OP_ADDI_W, 3, 0, 12'h7ff), 1, 3, 32'h7ff);
        // r1 three slots back here and r2 two slots back
        add_row(32'h1c00000c, i3r(core_pkg::OP_ADD_W, 4, 1, 2), 1, 4, 32'h2);
        add_row(32'h1c000010, i3r(core_pkg::OP_SUB_W, 5, 1, 2), 1, 5, 32'h8);
        add_row(32'h1c000014, i3r(core_pkg::OP_SLT, 6, 2, 1), 1, 6, 32'h1);    // -3 < 5
        add_row(32'h1c000018, i3r(core_pkg::OP_SLTU, 7, 2, 1), 1, 7, 32'h0);
        add_row(32'h1c00001c, i3r(core_pkg::OP_NOR, 8, 1, 2), 1, 8, 32'h2);
        add_row(32'h1c000020, i3r(core_pkg::OP_AND, 9, 1, 3), 1, 9, 32'h5);
        add_row(32'h1c000024, i3r(core_pkg::OP_OR, 10, 2, 3), 1, 10, 32'hffffffff);
        add_row(32'h1c000028, i3r(core_pkg::OP_XOR, 11, 1, 3), 1, 11, 32'h7fa);
        add_row(32'h1c00002c, i3r(core_pkg::OP_SLL_W, 12, 1, 1), 1, 12, 32'ha0);
        add_row(32'h1c000030, i3r(core_pkg::OP_SRL_W, 13, 2, 1), 1, 13, 32'h07ffffff);
        add_row(32'h1c000034, i3r(core_pkg::OP_SRA_W, 14, 2, 1), 1, 14, 32'hffffffff);
        // si12 0xfff is -1 when sign-extended and 0xfff when zero-extended
        add_row(32'h1c000038, i12(core_pkg::OP_ADDI_W, 15, 1, 12'hfff), 1, 15, 32'h4);
        add_row(32'h1c00003c, i12(core_pkg::OP_SLTI, 16, 2, 12'hffe), 1, 16, 32'h1);
        add_row(32'h1c000040, i12(core_pkg::OP_SLTUI, 17, 1, 12'hfff), 1, 17, 32'h1);
        add_row(32'h1c000044, i12(core_pkg::OP_ANDI, 18, 2, 12'hfff), 1, 18, 32'hffd);
        add_row(32'h1c000048, i12(core_pkg::OP_ORI, 19, 0, 12'h800), 1, 19, 32'h800);
        add_row(32'h1c00004c, i12(core_pkg::OP_XORI, 20, 2, 12'hfff), 1, 20, 32'hfffff002);
        // dependent chain where each one reads the previous rd
        add_row(32'h1c000050, i12(core_pkg::OP_ADDI_W, 21, 0, 12'h100), 1, 21, 32'h100);
        add_row(32'h1c000054, i3r(core_pkg::OP_ADD_W, 22, 21, 21), 1, 22, 32'h200);
        add_row(32'h1c000058, i12(core_pkg::OP_ADDI_W, 22, 22, 12'h001), 1, 22, 32'h201);
        add_row(32'h1c00005c, i3r(core_pkg::OP_SUB_W, 23, 22, 21), 1, 23, 32'h101);
        // r0 as target and then as source
        add_row(32'h1c000060, i12(core_pkg::OP_ADDI_W, 0, 1, 12'h007), 0, 0, 32'h0);
        add_row(32'h1c000064, i3r(core_pkg::OP_ADD_W, 24, 0, 1), 1, 24, 32'h5);
        // no opcode matches and the rd field is r31
        add_row(32'h1c000068, 32'hffffffff, 0, 31, 32'h0);
        add_bubble();
        add_bubble();
        add_row(32'h1c00006c, i3r(core_pkg::OP_OR, 25, 31, 0), 1, 25, 32'h0);  // r31 untouched
        add_row(32'h1c000070, i3r(core_pkg::OP_ADD_W, 26, 24, 15), 1, 26, 32'h9);
        add_bubble();
        add_row(32'h1c000074, i3r(core_pkg::OP_SLL_W, 27, 1, 12), 1, 27, 32'h5); // shamt 0xa0 -> 0
        add_row(32'h1c000078, i3r(core_pkg::OP_SRA_W, 28, 20, 1), 1, 28, 32'hffffff80);
        add_row(32'h1c00007c, i3r(core_pkg::OP_SLT, 29, 1, 2), 1, 29, 32'h0);
        add_row(32'h1c000080, i3r(core_pkg::OP_SLTU, 30, 1, 2), 1, 30, 32'h1);
        // rk alone forwarded in execute, then rj alone through the regfile bypass
        add_row(32'h1c000084, i3r(core_pkg::OP_SUB_W, 29, 28, 30), 1, 29, 32'hffffff7f);
        add_row(32'h1c000088, i3r(core_pkg::OP_AND, 31, 30, 29), 1, 31, 32'h1);
    end
endtask

/* testbench/tb_core.sv */
`default_nettype none

module tb_core;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] instr;
        logic        we;
        logic [4:0]  rd;
        logic [31:0] data;
    } vec_t;

    localparam int RESET_CYCLES = 5;

    logic                 clk;
    logic                 reset;
    core_pkg::fetch_pkt_t fetch;
    core_pkg::trace_t     trace;

    vec_t vectors[$];
    vec_t expected[$];   // pushed when driven and popped on retirement
    int   pass_cnt;
    int   fail_cnt;
    int   cycle_cnt;
    int   timeout_limit;
    logic stim_done;
    logic timed_out;

    core_top core_top_i
    (
        .clk     (clk),
        .reset   (reset),
        .fetch_i (fetch),
        .trace_o (trace)
    );

    // instruction word builders in LoongArch field layout
    function automatic logic [31:0] i3r(logic [16:0] op, int rd, int rj, int rk);
        return {op, rk[4:0], rj[4:0], rd[4:0]};
    endfunction

    function automatic logic [31:0] i12(logic [9:0] op, int rd, int rj, logic [11:0] imm);
        return {op, imm, rj[4:0], rd[4:0]};
    endfunction

    task automatic add_row(logic [31:0] pc, logic [31:0] instr, int we, int rd,
                           logic [31:0] data);
        vec_t row;
        row = '{valid: 1'b1, pc: pc, instr: instr, we: we[0], rd: rd[4:0], data: data};
        vectors.push_back(row);
    endtask

    task automatic add_bubble();
        vec_t row;
        row = '0;
        vectors.push_back(row);
    endtask

    `include "tb_vectors.svh"

    task automatic check_retire();
        vec_t  want;
        logic  ok;
        string got_s;
        string want_s;
        assert (expected.size() > 0)
        else
        begin
            $display("extra retirement at time %0t: pc %h retired with nothing outstanding",
                     $time, trace.pc);
            fail_cnt++;
        end
        if (expected.size() > 0)
        begin
            want = expected.pop_front();
            ok   = (trace.pc == want.pc) && (trace.we == want.we);
            if (want.we)
                ok = ok && (trace.rd == want.rd) && (trace.data == want.data);
            assert (ok)
            else
            begin
                got_s  = $sformatf("pc %h we %b rd %0d data %h",
                                   trace.pc, trace.we, trace.rd, trace.data);
                want_s = $sformatf("pc %h we %b rd %0d data %h",
                                   want.pc, want.we, want.rd, want.data);
                $display("** Error at %0t: %s, expected %s", $time, got_s, want_s);
                fail_cnt++;
            end
            if (ok)
            begin
                $display("pc %h retired ok", want.pc);
                pass_cnt++;
            end
        end
    endtask

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial
    begin
        reset     = 1'b0;
        fetch     = '0;
        stim_done = 1'b0;
        load_vectors();
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b1;
        foreach (vectors[i])
        begin
            @(posedge clk);
            fetch <= {vectors[i].valid, vectors[i].pc, vectors[i].instr};
            if (vectors[i].valid)
                expected.push_back(vectors[i]);
            else
                $display("row %0d is a bubble, nothing retires", i);
        end
        @(posedge clk);
        fetch     <= '0;
        stim_done = 1'b1;
    end

    // trace is stable around the falling edge
    always @(negedge clk)
    begin
        if (reset && trace.valid)
            check_retire();
    end

    initial
    begin
        cycle_cnt = 0;
        pass_cnt  = 0;
        fail_cnt  = 0;
        timed_out = 1'b0;
        @(posedge clk);
        timeout_limit = vectors.size() + RESET_CYCLES + 10;
        while (!(stim_done && expected.size() == 0) && !timed_out)
        begin
            @(negedge clk);
            cycle_cnt++;
            if (cycle_cnt > timeout_limit)
                timed_out = 1'b1;
        end
        repeat (3) @(posedge clk); // room for a stray retirement
        if (timed_out)
        begin
            $display("timeout after %0d cycles, %0d instructions never retired",
                     cycle_cnt, expected.size());
            fail_cnt++;
        end
        $display("retirements checked: %0d passed, %0d failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* hdl/core_top.sv */
`default_nettype none

module core_top
(
    input  wire                   clk,
    input  wire                   reset,
    input  core_pkg::fetch_pkt_t  fetch_i,
    output core_pkg::trace_t      trace_o
);

    core_pkg::reg_addr_t rj_addr;
    core_pkg::reg_addr_t rk_addr;
    core_pkg::word_t     rj_data;
    core_pkg::word_t     rk_data;
    core_pkg::ex_pkt_t   ex_pkt;   // decode -> execute
    core_pkg::wb_t       wb;       // execute -> regfile

    decode_stage decode_stage_i
    (
        .clk       (clk),
        .reset     (reset),
        .fetch_i   (fetch_i),
        .rj_addr_o (rj_addr),
        .rk_addr_o (rk_addr),
        .rj_data_i (rj_data),
        .rk_data_i (rk_data),
        .ex_o      (ex_pkt)
    );

    reg_file reg_file_i
    (
        .clk       (clk),
        .reset     (reset),
        .rj_addr_i (rj_addr),
        .rk_addr_i (rk_addr),
        .rj_data_o (rj_data),
        .rk_data_o (rk_data),
        .wb_i      (wb)
    );

    execute_stage execute_stage_i
    (
        .clk     (clk),
        .reset   (reset),
        .ex_i    (ex_pkt),
        .wb_o    (wb),
        .trace_o (trace_o)
    );

endmodule

`default_nettype wire

/* hdl/reg_file.sv */
`default_nettype none

module reg_file
(
    input  wire                  clk,
    input  wire                  reset,
    input  core_pkg::reg_addr_t  rj_addr_i,
    input  core_pkg::reg_addr_t  rk_addr_i,
    output core_pkg::word_t      rj_data_o,
    output core_pkg::word_t      rk_data_o,
    input  core_pkg::wb_t        wb_i
);

    core_pkg::word_t regs [32];
    logic            rj_hit;
    logic            rk_hit;

    // write-first, same-cycle writeback seen by decode
    assign rj_hit = wb_i.we && (wb_i.rd == rj_addr_i);
    assign rk_hit = wb_i.we && (wb_i.rd == rk_addr_i);

    assign rj_data_o = rj_hit ? wb_i.data : regs[rj_addr_i];
    assign rk_data_o = rk_hit ? wb_i.data : regs[rk_addr_i];

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            regs <= '{default: '0};
        end
        else if (wb_i.we)
        begin
            regs[wb_i.rd] <= wb_i.data; // r0 never addressed here
        end
    end

    // decoder drops we for rd == 0, so r0 stays zero
    a_no_r0_write: assert property (@(posedge clk) disable iff (!reset)
        wb_i.we |-> (wb_i.rd != '0));

endmodule

`default_nettype wire

/* hdl/decode_stage.sv */
`default_nettype none

module decode_stage
(
    input  wire                   clk,
    input  wire                   reset,
    input  core_pkg::fetch_pkt_t  fetch_i,
    output core_pkg::reg_addr_t   rj_addr_o,
    output core_pkg::reg_addr_t   rk_addr_o,
    input  core_pkg::word_t       rj_data_i,
    input  core_pkg::word_t       rk_data_i,
    output core_pkg::ex_pkt_t     ex_o
);

    core_pkg::instr_u  instr;
    core_pkg::word_t   imm_sext;
    core_pkg::word_t   imm_zext;
    core_pkg::ex_pkt_t ex_d;
    core_pkg::ex_pkt_t ex_q;
    logic              known;

    assign instr    = fetch_i.instr;
    assign imm_sext = {{20{instr.fmt_2ri12.si12[11]}}, instr.fmt_2ri12.si12};
    assign imm_zext = {20'b0, instr.fmt_2ri12.si12};

    // rj/rd sit in the same bits in both formats
    assign rj_addr_o = instr.fmt_3r.rj;
    assign rk_addr_o = instr.fmt_3r.rk;

    always_comb
    begin
        known       = 1'b1;
        ex_d.op     = core_pkg::ALU_ADD;
        ex_d.imm    = '0;
        ex_d.imm_sel = 1'b0;

        case (instr.fmt_3r.opcode)
            core_pkg::OP_ADD_W: ex_d.op = core_pkg::ALU_ADD;
            core_pkg::OP_SUB_W: ex_d.op = core_pkg::ALU_SUB;
            core_pkg::OP_SLT:   ex_d.op = core_pkg::ALU_SLT;
            core_pkg::OP_SLTU:  ex_d.op = core_pkg::ALU_SLTU;
            core_pkg::OP_NOR:   ex_d.op = core_pkg::ALU_NOR;
            core_pkg::OP_AND:   ex_d.op = core_pkg::ALU_AND;
            core_pkg::OP_OR:    ex_d.op = core_pkg::ALU_OR;
            core_pkg::OP_XOR:   ex_d.op = core_pkg::ALU_XOR;
            core_pkg::OP_SLL_W: ex_d.op = core_pkg::ALU_SLL;
            core_pkg::OP_SRL_W: ex_d.op = core_pkg::ALU_SRL;
            core_pkg::OP_SRA_W: ex_d.op = core_pkg::ALU_SRA;
            default:
            begin
                // not 3R, try the immediate view
                ex_d.imm_sel = 1'b1;
                ex_d.imm     = imm_sext;
                case (instr.fmt_2ri12.opcode)
                    core_pkg::OP_ADDI_W: ex_d.op = core_pkg::ALU_ADD;
                    core_pkg::OP_SLTI:   ex_d.op = core_pkg::ALU_SLT;
                    core_pkg::OP_SLTUI:  ex_d.op = core_pkg::ALU_SLTU;
                    core_pkg::OP_ANDI:
                    begin
                        ex_d.op  = core_pkg::ALU_AND;
                        ex_d.imm = imm_zext;
                    end
                    core_pkg::OP_ORI:
                    begin
                        ex_d.op  = core_pkg::ALU_OR;
                        ex_d.imm = imm_zext;
                    end
                    core_pkg::OP_XORI:
                    begin
                        ex_d.op  = core_pkg::ALU_XOR;
                        ex_d.imm = imm_zext;
                    end
                    default:
                    begin
                        known        = 1'b0; // retires as add, no write
                        ex_d.imm_sel = 1'b0;
                        ex_d.imm     = '0;
                    end
                endcase
            end
        endcase

        ex_d.valid  = fetch_i.valid;
        ex_d.pc     = fetch_i.pc;
        ex_d.rj     = instr.fmt_3r.rj;
        ex_d.rk     = instr.fmt_3r.rk;
        ex_d.rj_val = rj_data_i;
        ex_d.rk_val = rk_data_i;
        ex_d.rd     = instr.fmt_3r.rd;
        ex_d.we     = fetch_i.valid && known && (instr.fmt_3r.rd != '0);
    end

    always_ff @(posedge clk)
    begin
        ex_q <= ex_d;
        if (!reset)
        begin
            ex_q.valid <= 1'b0;
            ex_q.we    <= 1'b0;
        end
    end

    assign ex_o = ex_q;

    a_op_in_enum: assert property (@(posedge clk) disable iff (!reset)
        ex_q.valid |-> (ex_q.op inside {[core_pkg::ALU_ADD:core_pkg::ALU_SRA]}));

endmodule

`default_nettype wire

/* execute/execute_stage.sv */
`default_nettype none

module execute_stage
(
    input  wire                 clk,
    input  wire                 reset,
    input  core_pkg::ex_pkt_t   ex_i,
    output core_pkg::wb_t       wb_o,
    output core_pkg::trace_t    trace_o
);

    core_pkg::trace_t trace_q;
    core_pkg::word_t  a_fwd;
    core_pkg::word_t  b_fwd;
    core_pkg::word_t  b_sel;
    core_pkg::word_t  alu_res;
    logic             fwd_rj;
    logic             fwd_rk;

    // previous instruction still sits in trace_q
    assign fwd_rj = trace_q.we && (trace_q.rd == ex_i.rj);
    assign fwd_rk = trace_q.we && (trace_q.rd == ex_i.rk);

    assign a_fwd = fwd_rj ? trace_q.data : ex_i.rj_val;
    assign b_fwd = fwd_rk ? trace_q.data : ex_i.rk_val;

    assign b_sel = ex_i.imm_sel ? ex_i.imm : b_fwd;

    alu alu_i
    (
        .op_i     (ex_i.op),
        .a_i      (a_fwd),
        .b_i      (b_sel),
        .result_o (alu_res)
    );

    // writeback / trace register
    always_ff @(posedge clk)
    begin
        trace_q.valid <= ex_i.valid;
        trace_q.pc    <= ex_i.pc;
        trace_q.we    <= ex_i.we;
        trace_q.rd    <= ex_i.rd;
        trace_q.data  <= alu_res;
        if (!reset)
        begin
            trace_q.valid <= 1'b0;
            trace_q.we    <= 1'b0;
        end
    end

    assign wb_o = '{we: trace_q.we, rd: trace_q.rd, data: trace_q.data};

    assign trace_o = trace_q;

    // bubbles from decode must never write
    a_we_needs_valid: assert property (@(posedge clk) disable iff (!reset)
        trace_q.we |-> trace_q.valid);

endmodule

`default_nettype wire

/* execute/alu.sv */
`default_nettype none

module alu
(
    input  core_pkg::alu_op_e  op_i,
    input  core_pkg::word_t    a_i,
    input  core_pkg::word_t    b_i,
    output core_pkg::word_t    result_o
);

    logic [4:0] shamt;
    logic       lt_s;
    logic       lt_u;

    assign shamt = b_i[4:0];  // only low 5 bits count
    assign lt_s  = $signed(a_i) < $signed(b_i);
    assign lt_u  = a_i < b_i;

    always_comb
    begin
        case (op_i)
            core_pkg::ALU_ADD:  result_o = a_i + b_i;   // wraps
            core_pkg::ALU_SUB:  result_o = a_i - b_i;
            core_pkg::ALU_SLT:  result_o = {31'b0, lt_s};
            core_pkg::ALU_SLTU: result_o = {31'b0, lt_u};
            core_pkg::ALU_NOR:  result_o = ~(a_i | b_i);
            core_pkg::ALU_AND:  result_o = a_i & b_i;
            core_pkg::ALU_OR:   result_o = a_i | b_i;
            core_pkg::ALU_XOR:  result_o = a_i ^ b_i;
            core_pkg::ALU_SLL:  result_o = a_i << shamt;
            core_pkg::ALU_SRL:  result_o = a_i >> shamt;
            core_pkg::ALU_SRA:  result_o = $signed(a_i) >>> shamt;
            default:            result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

/* common/core_pkg.sv */
`default_nettype none

package core_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // three-register format
    typedef struct packed {
        logic [16:0] opcode;
        reg_addr_t   rk;
        reg_addr_t   rj;
        reg_addr_t   rd;
    } fmt_3r_t;

    // register plus 12-bit immediate format
    typedef struct packed {
        logic [9:0]  opcode;
        logic [11:0] si12;
        reg_addr_t   rj;
        reg_addr_t   rd;
    } fmt_2ri12_t;

    // same word, both views looked at by the decoder
    typedef union packed {
        fmt_3r_t    fmt_3r;
        fmt_2ri12_t fmt_2ri12;
    } instr_u;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_NOR,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA
    } alu_op_e;

    // 3R opcodes, inst[31:15]
    localparam logic [16:0] OP_ADD_W  = 17'h00020;
    localparam logic [16:0] OP_SUB_W  = 17'h00022;
    localparam logic [16:0] OP_SLT    = 17'h00024;
    localparam logic [16:0] OP_SLTU   = 17'h00025;
    localparam logic [16:0] OP_NOR    = 17'h00028;
    localparam logic [16:0] OP_AND    = 17'h00029;
    localparam logic [16:0] OP_OR     = 17'h0002a;
    localparam logic [16:0] OP_XOR    = 17'h0002b;
    localparam logic [16:0] OP_SLL_W  = 17'h0002e;
    localparam logic [16:0] OP_SRL_W  = 17'h0002f;
    localparam logic [16:0] OP_SRA_W  = 17'h00030;

    // 2RI12 opcodes, inst[31:22]
    localparam logic [9:0]  OP_SLTI   = 10'h008;
    localparam logic [9:0]  OP_SLTUI  = 10'h009;
    localparam logic [9:0]  OP_ADDI_W = 10'h00a;
    localparam logic [9:0]  OP_ANDI   = 10'h00d;
    localparam logic [9:0]  OP_ORI    = 10'h00e;
    localparam logic [9:0]  OP_XORI   = 10'h00f;

    typedef struct packed {
        logic   valid;
        word_t  pc;
        instr_u instr;
    } fetch_pkt_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        alu_op_e   op;
        reg_addr_t rj;      // source numbers kept for forwarding
        reg_addr_t rk;
        word_t     rj_val;
        word_t     rk_val;
        word_t     imm;
        logic      imm_sel; // operand b from imm
        reg_addr_t rd;
        logic      we;
    } ex_pkt_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        logic      we;
        reg_addr_t rd;
        word_t     data;
    } trace_t;

    typedef struct packed {
        logic      we;
        reg_addr_t rd;
        word_t     data;
    } wb_t;

endpackage

`default_nettype wire
